// ==== hw/smwa_defines.svh ====
/*
 * alignment front end constants
 * stream and score widths, header layout, bus map and version word
 */
`ifndef SMWA_DEFINES_SVH
`define SMWA_DEFINES_SVH

////////////////////////////////////////////////////////////
// stream format
////////////////////////////////////////////////////////////

// one stream beat
`define SMWA_STREAM_W 128
// 2-bit base encoding
`define SMWA_BASE_W 2
// bases packed into one data beat
`define SMWA_BASES_PER_WORD (`SMWA_STREAM_W / `SMWA_BASE_W)
// base count sits in the low bits of a header beat
`define SMWA_LEN_W 16

// signed score width, two's complement
`define SMWA_SCORE_W 9

////////////////////////////////////////////////////////////
// picobus map
////////////////////////////////////////////////////////////

`define SMWA_VERSION 32'h0001

`define SMWA_ADDR_VERSION      32'h000
`define SMWA_ADDR_IN_COUNT     32'h010
`define SMWA_ADDR_STATUS       32'h030
`define SMWA_ADDR_TARGET_COUNT 32'h080
`define SMWA_ADDR_QUERY_COUNT  32'h090
`define SMWA_ADDR_MATCH        32'h100
`define SMWA_ADDR_MISMATCH     32'h110
`define SMWA_ADDR_GAP_OPEN     32'h120

`endif

// ==== hw/smwa_pkg.sv ====
/*
 * alignment front end types
 * vector types for the stream, bus, scores and counts, plus demux states
 */
`include "smwa_defines.svh"

package smwa_pkg;

    // one 128-bit stream beat
    typedef logic [`SMWA_STREAM_W-1:0] stream_word_t;

    // picobus address and data
    typedef logic [31:0] bus_word_t;

    // alignment score, signed
    typedef logic signed [`SMWA_SCORE_W-1:0] score_t;

    // base count taken from a header beat
    typedef logic [`SMWA_LEN_W-1:0] seq_len_t;

    // data beats left in a sequence, minus one
    // 16-bit length over 64 bases per beat leaves 10 bits
    typedef logic [`SMWA_LEN_W-$clog2(`SMWA_BASES_PER_WORD)-1:0] word_count_t;

    // handshake counter
    typedef logic [31:0] xfer_count_t;

    // demux walks query header/data then target header/data
    typedef enum logic [1:0] {
        hdr_query,
        data_query,
        hdr_target,
        data_target
    } demux_state_t;

endpackage

// ==== hw/stream_demux.sv ====
/*
 * input stream demultiplexer
 * eats the header beat of each sequence and steers the data beats
 * to the query or target side, alternating query then target
 */
`include "smwa_defines.svh"

module stream_demux (
    input  logic                  PicoClk,
    input  logic                  rst,

    // combined input stream
    input  logic                  s1i_valid,
    output logic                  s1i_rdy,
    input  smwa_pkg::stream_word_t s1i_data,

    // query side
    output logic                  query_valid,
    input  logic                  query_ready,
    output smwa_pkg::stream_word_t query_data,

    // target side
    output logic                  target_valid,
    input  logic                  target_ready,
    output smwa_pkg::stream_word_t target_data
);

    import smwa_pkg::*;

    // log2 of bases per beat, used to turn a base count into beats
    localparam int WORD_SHIFT = $clog2(`SMWA_BASES_PER_WORD);

    ////////////////////////////////////////////////////////////
    // header decode
    ////////////////////////////////////////////////////////////

    demux_state_t state;
    word_count_t  words_left;

    logic         s1i_xfer;
    seq_len_t     hdr_len;
    seq_len_t     hdr_len_m1;
    word_count_t  hdr_words_m1;
    logic         hdr_empty;
    logic         last_word;

    assign s1i_xfer = s1i_valid && s1i_rdy;

    // base count lives in the low bits of the header
    assign hdr_len   = s1i_data[`SMWA_LEN_W-1:0];
    assign hdr_empty = (hdr_len == '0);

    // ceil(L/64) - 1 = (L-1) >> 6 for L > 0
    // keeps 65535 bases inside the 10-bit counter
    assign hdr_len_m1   = hdr_len - 1'b1;
    assign hdr_words_m1 = hdr_len_m1[`SMWA_LEN_W-1:WORD_SHIFT];

    assign last_word = (words_left == '0);

    ////////////////////////////////////////////////////////////
    // sequence FSM
    ////////////////////////////////////////////////////////////

    // only moves on a completed input handshake
    always_ff @(posedge PicoClk) begin
        if (rst) begin
            state      <= hdr_query;
            words_left <= '0;
        end else if (s1i_xfer) begin
            case (state)
                hdr_query: begin
                    words_left <= hdr_words_m1;
                    // zero-length query goes straight to the target header
                    state      <= hdr_empty ? hdr_target : data_query;
                end
                data_query: begin
                    words_left <= words_left - 1'b1;
                    if (last_word) begin
                        state <= hdr_target;
                    end
                end
                hdr_target: begin
                    words_left <= hdr_words_m1;
                    state      <= hdr_empty ? hdr_query : data_target;
                end
                data_target: begin
                    words_left <= words_left - 1'b1;
                    if (last_word) begin
                        state <= hdr_query;
                    end
                end
                default: begin
                    state <= hdr_query;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // steering
    ////////////////////////////////////////////////////////////

    // headers are always accepted, data waits on its destination
    always_comb begin
        case (state)
            data_query:  s1i_rdy = query_ready;
            data_target: s1i_rdy = target_ready;
            default:     s1i_rdy = 1'b1;
        endcase
    end

    // same-cycle pass-through of data beats, no buffering
    assign query_valid  = s1i_valid && (state == data_query);
    assign target_valid = s1i_valid && (state == data_target);

    // both sides see the beat, valid picks the owner
    assign query_data  = s1i_data;
    assign target_data = s1i_data;

endmodule

// ==== hw/score_regs.sv ====
/*
 * scoring registers
 * match, mismatch and gap-open scores, written and read over the picobus
 */
`include "smwa_defines.svh"

module score_regs (
    input  logic               PicoClk,
    input  logic               rst,

    input  smwa_pkg::bus_word_t pico_addr,
    input  smwa_pkg::bus_word_t pico_data_in,
    input  logic               pico_rd,
    input  logic               pico_wr,
    output smwa_pkg::bus_word_t pico_data_out,

    // scores toward the alignment engine
    output smwa_pkg::score_t   match,
    output smwa_pkg::score_t   mismatch,
    output smwa_pkg::score_t   gap_open
);

    import smwa_pkg::*;

    // widen a score to a bus word, keeping its sign
    function automatic bus_word_t sext(input score_t s);
        return {{(32-`SMWA_SCORE_W){s[`SMWA_SCORE_W-1]}}, s};
    endfunction

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    // only the low score bits of the bus word are kept
    always_ff @(posedge PicoClk) begin
        if (rst) begin
            match    <= '0;
            mismatch <= '0;
            gap_open <= '0;
        end else if (pico_wr) begin
            case (pico_addr)
                `SMWA_ADDR_MATCH:    match    <= score_t'(pico_data_in[`SMWA_SCORE_W-1:0]);
                `SMWA_ADDR_MISMATCH: mismatch <= score_t'(pico_data_in[`SMWA_SCORE_W-1:0]);
                `SMWA_ADDR_GAP_OPEN: gap_open <= score_t'(pico_data_in[`SMWA_SCORE_W-1:0]);
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // zero unless the previous cycle read one of our addresses
    always_ff @(posedge PicoClk) begin
        if (rst) begin
            pico_data_out <= '0;
        end else begin
            pico_data_out <= '0;
            if (pico_rd) begin
                case (pico_addr)
                    `SMWA_ADDR_MATCH:    pico_data_out <= sext(match);
                    `SMWA_ADDR_MISMATCH: pico_data_out <= sext(mismatch);
                    `SMWA_ADDR_GAP_OPEN: pico_data_out <= sext(gap_open);
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/xfer_monitor.sv ====
/*
 * transfer monitor
 * counts handshakes on the input, query and target streams, keeps a
 * handshake status snapshot and serves version and counters on the picobus
 */
`include "smwa_defines.svh"

module xfer_monitor (
    input  logic               PicoClk,
    input  logic               rst,

    // observed handshakes
    input  logic               s1i_valid,
    input  logic               s1i_rdy,
    input  logic               query_valid,
    input  logic               query_ready,
    input  logic               target_valid,
    input  logic               target_ready,

    // read-only bus port
    input  smwa_pkg::bus_word_t pico_addr,
    input  logic               pico_rd,
    output smwa_pkg::bus_word_t pico_data_out
);

    import smwa_pkg::*;

    xfer_count_t in_count;
    xfer_count_t query_count;
    xfer_count_t target_count;
    bus_word_t   status;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PicoClk) begin
        if (rst) begin
            in_count     <= '0;
            query_count  <= '0;
            target_count <= '0;
        end else begin
            // headers and data beats
            if (s1i_valid && s1i_rdy) begin
                in_count <= in_count + 1'b1;
            end
            if (query_valid && query_ready) begin
                query_count <= query_count + 1'b1;
            end
            if (target_valid && target_ready) begin
                target_count <= target_count + 1'b1;
            end
        end
    end

    // one nibble per stream: input [11:8], target [7:4], query [3:0]
    // valid above rdy in each nibble
    always_ff @(posedge PicoClk) begin
        status <= {20'b0,
                   2'b0, s1i_valid, s1i_rdy,
                   2'b0, target_valid, target_ready,
                   2'b0, query_valid, query_ready};
    end

    ////////////////////////////////////////////////////////////
    // bus readback
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PicoClk) begin
        if (rst) begin
            pico_data_out <= '0;
        end else begin
            pico_data_out <= '0;
            if (pico_rd) begin
                case (pico_addr)
                    `SMWA_ADDR_VERSION:      pico_data_out <= `SMWA_VERSION;
                    `SMWA_ADDR_IN_COUNT:     pico_data_out <= in_count;
                    `SMWA_ADDR_STATUS:       pico_data_out <= status;
                    `SMWA_ADDR_TARGET_COUNT: pico_data_out <= target_count;
                    `SMWA_ADDR_QUERY_COUNT:  pico_data_out <= query_count;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/smwa_front.sv ====
/*
 * alignment engine front end
 * splits the input stream into query and target, holds the scores
 * and merges the picobus read data of its blocks
 */
module smwa_front (
    input  logic                   PicoClk,
    input  logic                   rst,

    // combined input stream
    input  logic                   s1i_valid,
    output logic                   s1i_rdy,
    input  smwa_pkg::stream_word_t s1i_data,

    // query stream toward the engine
    output logic                   query_valid,
    input  logic                   query_ready,
    output smwa_pkg::stream_word_t query_data,

    // target stream toward the engine
    output logic                   target_valid,
    input  logic                   target_ready,
    output smwa_pkg::stream_word_t target_data,

    // picobus
    input  smwa_pkg::bus_word_t    pico_addr,
    input  smwa_pkg::bus_word_t    pico_data_in,
    input  logic                   pico_rd,
    input  logic                   pico_wr,
    output smwa_pkg::bus_word_t    pico_data_out,

    // scoring values
    output smwa_pkg::score_t       match,
    output smwa_pkg::score_t       mismatch,
    output smwa_pkg::score_t       gap_open
);

    import smwa_pkg::*;

    // per-block read data, zero when idle
    bus_word_t score_rdata;
    bus_word_t monitor_rdata;

    ////////////////////////////////////////////////////////////
    // stream path
    ////////////////////////////////////////////////////////////

    stream_demux u_demux (
        .PicoClk      (PicoClk),
        .rst          (rst),
        .s1i_valid    (s1i_valid),
        .s1i_rdy      (s1i_rdy),
        .s1i_data     (s1i_data),
        .query_valid  (query_valid),
        .query_ready  (query_ready),
        .query_data   (query_data),
        .target_valid (target_valid),
        .target_ready (target_ready),
        .target_data  (target_data)
    );

    ////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////

    score_regs u_scores (
        .PicoClk       (PicoClk),
        .rst           (rst),
        .pico_addr     (pico_addr),
        .pico_data_in  (pico_data_in),
        .pico_rd       (pico_rd),
        .pico_wr       (pico_wr),
        .pico_data_out (score_rdata),
        .match         (match),
        .mismatch      (mismatch),
        .gap_open      (gap_open)
    );

    // watches the same handshakes the demux produces
    xfer_monitor u_monitor (
        .PicoClk       (PicoClk),
        .rst           (rst),
        .s1i_valid     (s1i_valid),
        .s1i_rdy       (s1i_rdy),
        .query_valid   (query_valid),
        .query_ready   (query_ready),
        .target_valid  (target_valid),
        .target_ready  (target_ready),
        .pico_addr     (pico_addr),
        .pico_rd       (pico_rd),
        .pico_data_out (monitor_rdata)
    );

    // address ranges are disjoint, so an OR merges the read data
    assign pico_data_out = score_rdata | monitor_rdata;

endmodule

// ==== test/smwa_front_chk.sv ====
/*
 * front end protocol checker
 * assertions on stream steering and idle picobus read data
 */
module smwa_front_chk (
    input  logic                   PicoClk,
    input  logic                   rst,
    input  smwa_pkg::demux_state_t state,
    input  logic                   query_valid,
    input  logic                   target_valid,
    input  logic                   pico_rd,
    input  smwa_pkg::bus_word_t    pico_data_out
);

    import smwa_pkg::*;

    // a data beat has exactly one owner
    a_one_owner: assert property (@(posedge PicoClk) disable iff (rst)
        !(query_valid && target_valid))
        else $error("query and target valid high in the same cycle");

    // header beats are swallowed, never forwarded
    a_hdr_quiet: assert property (@(posedge PicoClk) disable iff (rst)
        (state == hdr_query || state == hdr_target) |-> !(query_valid || target_valid))
        else $error("stream output valid while the demux expects a header");

    // read data only in the cycle after a read strobe
    a_idle_rdata: assert property (@(posedge PicoClk) disable iff (rst)
        !pico_rd |=> (pico_data_out == '0))
        else $error("read data nonzero without a preceding read");

endmodule

bind smwa_front smwa_front_chk chk (
    .PicoClk       (PicoClk),
    .rst           (rst),
    .state         (u_demux.state),
    .query_valid   (query_valid),
    .target_valid  (target_valid),
    .pico_rd       (pico_rd),
    .pico_data_out (pico_data_out)
);

// ==== test/smwa_front_tb.sv ====
/*
 * testbench for the alignment front end
 * random query/target sequences under back-pressure, score register
 * traffic and counter readback, all against a model kept here
 */
`include "smwa_defines.svh"

module smwa_front_tb;

    import smwa_pkg::*;

    localparam int NUM_SEQS  = 40;
    localparam int MAX_BASES = 300;

    // what each input beat is, which also tells the demux state
    localparam int KIND_HDR    = 0;
    localparam int KIND_QUERY  = 1;
    localparam int KIND_TARGET = 2;

    logic         PicoClk;
    logic         rst;
    logic         s1i_valid;
    logic         s1i_rdy;
    stream_word_t s1i_data;
    logic         query_valid;
    logic         query_ready;
    stream_word_t query_data;
    logic         target_valid;
    logic         target_ready;
    stream_word_t target_data;
    bus_word_t    pico_addr;
    bus_word_t    pico_data_in;
    logic         pico_rd;
    logic         pico_wr;
    bus_word_t    pico_data_out;
    score_t       match;
    score_t       mismatch;
    score_t       gap_open;

    // stimulus and model state
    logic [31:0]  rng;
    stream_word_t in_beats[$];
    int           in_kinds[$];
    int           beat_idx = 0;
    stream_word_t exp_query[$];
    stream_word_t exp_target[$];
    int           total_query_words = 0;
    int           total_target_words = 0;
    xfer_count_t  model_in_count;
    xfer_count_t  model_query_count;
    xfer_count_t  model_target_count;
    score_t       model_match;
    score_t       model_mismatch;
    score_t       model_gap_open;
    logic         in_xfer;
    logic         rd_last;
    int           limit_cycles = 0;
    int           word_errs = 0;
    int           score_errs = 0;
    int           bus_errs = 0;
    int           flag_errs = 0;
    int           other_errs = 0;

    smwa_front uut (
        .PicoClk (PicoClk), .rst (rst),
        .s1i_valid (s1i_valid), .s1i_rdy (s1i_rdy), .s1i_data (s1i_data),
        .query_valid (query_valid), .query_ready (query_ready), .query_data (query_data),
        .target_valid (target_valid), .target_ready (target_ready),
        .target_data (target_data),
        .pico_addr (pico_addr), .pico_data_in (pico_data_in), .pico_rd (pico_rd),
        .pico_wr (pico_wr), .pico_data_out (pico_data_out),
        .match (match), .mismatch (mismatch), .gap_open (gap_open)
    );

    always #20 PicoClk = ~PicoClk;

    ////////////////////////////////////////////////////////////
    // random source and compare tasks
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_word(input stream_word_t got, input stream_word_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            score_errs++;
            $display("[FAIL] %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bus(input bus_word_t got, input bus_word_t exp, input string what);
        if (got !== exp) begin
            bus_errs++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("[FAIL] %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // register model and bus access
    ////////////////////////////////////////////////////////////

    // scores come back sign-extended, unmapped addresses read zero
    function automatic bus_word_t expected_read(input bus_word_t addr);
        case (addr)
            `SMWA_ADDR_VERSION:      return `SMWA_VERSION;
            `SMWA_ADDR_IN_COUNT:     return model_in_count;
            // reads only run with streams idle and the demux on a header
            `SMWA_ADDR_STATUS:       return 32'h0000_0100;
            `SMWA_ADDR_TARGET_COUNT: return model_target_count;
            `SMWA_ADDR_QUERY_COUNT:  return model_query_count;
            `SMWA_ADDR_MATCH:        return bus_word_t'(model_match);
            `SMWA_ADDR_MISMATCH:     return bus_word_t'(model_mismatch);
            `SMWA_ADDR_GAP_OPEN:     return bus_word_t'(model_gap_open);
            default:                 return '0;
        endcase
    endfunction

    task automatic bus_write(input bus_word_t addr, input bus_word_t data);
        @(negedge PicoClk);
        pico_addr    = addr;
        pico_data_in = data;
        pico_wr      = 1'b1;
        @(negedge PicoClk);
        pico_wr = 1'b0;
    endtask

    // data is registered at the edge between the two falling edges
    task automatic bus_read_check(input bus_word_t addr, input string what);
        @(negedge PicoClk);
        pico_addr = addr;
        pico_rd   = 1'b1;
        @(negedge PicoClk);
        pico_rd = 1'b0;
        check_bus(pico_data_out, expected_read(addr), what);
    endtask

    task automatic read_all(input string when);
        bus_read_check(`SMWA_ADDR_VERSION, {"version ", when});
        bus_read_check(`SMWA_ADDR_IN_COUNT, {"input count ", when});
        bus_read_check(`SMWA_ADDR_STATUS, {"status ", when});
        bus_read_check(`SMWA_ADDR_TARGET_COUNT, {"target count ", when});
        bus_read_check(`SMWA_ADDR_QUERY_COUNT, {"query count ", when});
        bus_read_check(`SMWA_ADDR_MATCH, {"match ", when});
        bus_read_check(`SMWA_ADDR_MISMATCH, {"mismatch ", when});
        bus_read_check(`SMWA_ADDR_GAP_OPEN, {"gap open ", when});
        // holes in the map read as zero
        bus_read_check(32'h0000_0020, {"unmapped ", when});
        // high address bits take part in the decode
        bus_read_check(32'h0001_0100, {"match alias ", when});
    endtask

    // random writes, only the low score bits survive
    task automatic score_round();
        bus_word_t v;
        v = next_rand();
        bus_write(`SMWA_ADDR_MATCH, v);
        model_match = score_t'(v[`SMWA_SCORE_W-1:0]);
        v = next_rand();
        bus_write(`SMWA_ADDR_MISMATCH, v);
        model_mismatch = score_t'(v[`SMWA_SCORE_W-1:0]);
        v = next_rand();
        bus_write(`SMWA_ADDR_GAP_OPEN, v);
        model_gap_open = score_t'(v[`SMWA_SCORE_W-1:0]);
        // a stray write next to the map must not disturb anything
        bus_write(32'h130, next_rand());
        check_score(match, model_match, "match port");
        check_score(mismatch, model_mismatch, "mismatch port");
        check_score(gap_open, model_gap_open, "gap open port");
        bus_read_check(`SMWA_ADDR_MATCH, "match readback");
        bus_read_check(`SMWA_ADDR_MISMATCH, "mismatch readback");
        bus_read_check(`SMWA_ADDR_GAP_OPEN, "gap open readback");
    endtask

    ////////////////////////////////////////////////////////////
    // stream traffic
    ////////////////////////////////////////////////////////////

    function automatic stream_word_t rand_word();
        stream_word_t w;
        w[31:0]   = next_rand();
        w[63:32]  = next_rand();
        w[95:64]  = next_rand();
        w[127:96] = next_rand();
        return w;
    endfunction

    // even index is a query, odd index a target
    task automatic build_traffic();
        int i;
        int j;
        int len;
        int words;
        stream_word_t w;
        for (i = 0; i < NUM_SEQS; i++) begin
            len = int'(next_rand() % (MAX_BASES + 1));
            // empty sequences every so often, on both sides
            if (i % 5 == 3) begin
                len = 0;
            end
            words = (len + `SMWA_BASES_PER_WORD - 1) / `SMWA_BASES_PER_WORD;
            w = rand_word();
            w[`SMWA_LEN_W-1:0] = seq_len_t'(len);
            in_beats.push_back(w);
            in_kinds.push_back(KIND_HDR);
            for (j = 0; j < words; j++) begin
                w = rand_word();
                in_beats.push_back(w);
                if (i % 2 == 0) begin
                    exp_query.push_back(w);
                    in_kinds.push_back(KIND_QUERY);
                end else begin
                    exp_target.push_back(w);
                    in_kinds.push_back(KIND_TARGET);
                end
            end
        end
        total_query_words  = exp_query.size();
        total_target_words = exp_target.size();
    endtask

    task automatic send_traffic();
        while (beat_idx < in_beats.size()) begin
            @(negedge PicoClk);
            // the beat on the bus went through at the last rising edge
            if (s1i_valid && in_xfer) begin
                beat_idx++;
            end
            query_ready  = (next_rand() & 32'h3) != 0;
            target_ready = (next_rand() & 32'h3) != 0;
            if (beat_idx >= in_beats.size()) begin
                s1i_valid = 1'b0;
            end else if (!(s1i_valid && !in_xfer)) begin
                // next beat or a gap, a stalled beat stays put
                s1i_valid = (next_rand() & 32'h3) != 0;
                s1i_data  = in_beats[beat_idx];
            end
        end
        repeat (4) @(negedge PicoClk);
        query_ready  = 1'b0;
        target_ready = 1'b0;
        model_in_count = xfer_count_t'(in_beats.size());
        if (exp_query.size() != 0 || exp_target.size() != 0) begin
            other_errs++;
            $display("words never arrived: %0d query, %0d target",
                     exp_query.size(), exp_target.size());
        end
    endtask

    // kind of the beat the demux waits for
    // after the last beat it waits for a query header
    function automatic int kind_now();
        if (beat_idx < in_kinds.size()) begin
            return in_kinds[beat_idx];
        end
        return KIND_HDR;
    endfunction

    // header beats are always taken, data waits on its side
    function automatic logic expected_rdy(input int kind);
        case (kind)
            KIND_QUERY:  return query_ready;
            KIND_TARGET: return target_ready;
            default:     return 1'b1;
        endcase
    endfunction

    // output beats, handshake flag for the driver, idle read data
    always @(posedge PicoClk) begin
        if (rst) begin
            in_xfer = 1'b0;
            rd_last = 1'b0;
        end else begin
            in_xfer = s1i_valid && s1i_rdy;
            // steering and ready follow the kind of the pending beat
            check_flag(query_valid, s1i_valid && kind_now() == KIND_QUERY, "query valid");
            check_flag(target_valid, s1i_valid && kind_now() == KIND_TARGET, "target valid");
            check_flag(s1i_rdy, expected_rdy(kind_now()), "input ready");
            if (query_valid && query_ready) begin
                if (exp_query.size() == 0) begin
                    other_errs++;
                    $display("query side got a word nobody sent at time %0t", $time);
                end else begin
                    check_word(query_data, exp_query.pop_front(), "query word");
                end
            end
            if (target_valid && target_ready) begin
                if (exp_target.size() == 0) begin
                    other_errs++;
                    $display("target side got a word nobody sent at time %0t", $time);
                end else begin
                    check_word(target_data, exp_target.pop_front(), "target word");
                end
            end
            if (!rd_last) begin
                check_bus(pico_data_out, '0, "read data without a read");
            end
            rd_last = pico_rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // sequence and verdict
    ////////////////////////////////////////////////////////////

    initial begin
        PicoClk      = 1'b0;
        rst          = 1'b1;
        s1i_valid    = 1'b0;
        s1i_data     = '0;
        query_ready  = 1'b0;
        target_ready = 1'b0;
        pico_addr    = '0;
        pico_data_in = '0;
        pico_rd      = 1'b0;
        pico_wr      = 1'b0;
        rng          = 32'hf131;
        model_match    = '0;
        model_mismatch = '0;
        model_gap_open = '0;
        model_in_count = '0;
        model_query_count  = '0;
        model_target_count = '0;
        build_traffic();
        limit_cycles = 40 * in_beats.size() + 2000;
        repeat (2) @(posedge PicoClk);
        @(negedge PicoClk);
        rst = 1'b0;
        read_all("after reset");
        repeat (4) score_round();
        send_traffic();
        // every data beat reaches its side exactly once
        model_query_count  = xfer_count_t'(total_query_words);
        model_target_count = xfer_count_t'(total_target_words);
        read_all("after traffic");
        repeat (4) @(negedge PicoClk);
        $display("errors: word %0d score %0d bus %0d flag %0d other %0d",
                 word_errs, score_errs, bus_errs, flag_errs, other_errs);
        if (word_errs + score_errs + bus_errs + flag_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge PicoClk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/smwa_pkg.sv
hw/stream_demux.sv
hw/score_regs.sv
hw/xfer_monitor.sv
hw/smwa_front.sv
test/smwa_front_chk.sv
test/smwa_front_tb.sv

// ==== Makefile ====
# Verilator flow for the alignment front end

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= smwa_front_tb
RTL_TOP    ?= smwa_front
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	out=$$(./$(OBJ_DIR)/V$(TB_TOP) $(RUN_ARGS)); echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
